// File: hdl/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // byte address space of the instruction memory.
    localparam int IADDR_BITS = 16;

    // word address sent to memory, the two byte bits dropped.
    localparam int WADDR_BITS = IADDR_BITS - 2;

    // instruction and memory word width.
    localparam int INSN_WIDTH = 32;

    // word queue between memory and aligner.
    localparam int QDEPTH_BITS = 2;
    localparam int QDEPTH      = 2 ** QDEPTH_BITS;

    // occupancy runs 0..QDEPTH, so one bit more than the index.
    localparam int QCOUNT_BITS = QDEPTH_BITS + 1;

    // halfword address of the first instruction after reset.
    localparam logic [IADDR_BITS-1:1] RESET_PC = '0;

    // fetch controller states.
    // FS_BOOT  loads the reset pc into the aligner.
    // FS_RUN   requests words while the queue has room.
    // FS_FLUSH drops a response still in flight from the old path.
    typedef enum logic [1:0]
    {
        FS_BOOT  = 2'd0,
        FS_RUN   = 2'd1,
        FS_FLUSH = 2'd2
    } fetch_state_t;

endpackage

// File: hdl/fetch_ctrl.sv
module fetch_ctrl
(
    input  wire                                     i_clk,
    input  wire                                     i_arst_n,
    input  wire                                     i_redirect,
    input  wire [rv_fetch_pkg::IADDR_BITS-1:1]      i_redirect_pc,
    input  wire                                     i_imem_valid,
    input  wire [rv_fetch_pkg::QCOUNT_BITS-1:0]     i_q_count,
    output logic                                    o_imem_req,
    output logic [rv_fetch_pkg::WADDR_BITS-1:0]     o_imem_addr,
    output logic                                    o_q_push,
    output logic                                    o_flush,
    output logic                                    o_align_load,
    output logic [rv_fetch_pkg::IADDR_BITS-1:1]     o_load_pc
);

    import rv_fetch_pkg::*;

    fetch_state_t               state;
    fetch_state_t               state_next;
    logic [WADDR_BITS-1:0]      waddr;          // next word to request.
    logic                       outstanding;    // a request awaits its response.
    logic [QCOUNT_BITS-1:0]     credit_used;
    logic                       has_credit;

    // words queued plus the one in flight must stay within the queue.
    assign credit_used = i_q_count + QCOUNT_BITS'(outstanding);
    assign has_credit  = credit_used < QCOUNT_BITS'(QDEPTH);

    // a request in the redirect cycle is harmless, FS_FLUSH drops its reply.
    assign o_imem_req  = (state == FS_RUN) & has_credit;
    assign o_imem_addr = waddr;

    // memory latency is fixed at one cycle, so data is pushed on arrival.
    assign o_q_push = i_imem_valid & (state == FS_RUN);

    assign o_flush = i_redirect;

    // aligner pc load at boot and on every redirect.
    assign o_align_load = i_redirect | (state == FS_BOOT);
    assign o_load_pc    = i_redirect ? i_redirect_pc : RESET_PC;

    always_comb
    begin
        state_next = state;
        if (i_redirect)
        begin
            state_next = FS_FLUSH;
        end
        else
        begin
            case (state)
                FS_BOOT:  state_next = FS_RUN;
                FS_FLUSH: state_next = FS_RUN;   // one cycle is enough.
                default:  state_next = state;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state <= FS_BOOT;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            outstanding <= 1'b0;
        end
        else if (o_imem_req)
        begin
            outstanding <= 1'b1;
        end
        else if (i_imem_valid)
        begin
            outstanding <= 1'b0;
        end
    end

    // restart from the word that holds the loaded pc.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            waddr <= '0;
        end
        else if (o_align_load)
        begin
            waddr <= o_load_pc[IADDR_BITS-1:2];
        end
        else if (o_imem_req)
        begin
            waddr <= waddr + WADDR_BITS'(1);
        end
    end

endmodule

// File: hdl/fetch_queue.sv
module fetch_queue
(
    input  wire                                     i_clk,
    input  wire                                     i_arst_n,
    input  wire                                     i_flush,
    input  wire                                     i_push,
    input  wire [rv_fetch_pkg::INSN_WIDTH-1:0]      i_data,
    input  wire                                     i_pop,
    output logic [rv_fetch_pkg::INSN_WIDTH-1:0]     o_head,
    output logic [rv_fetch_pkg::QCOUNT_BITS-1:0]    o_count,
    output logic                                    o_not_empty
);

    import rv_fetch_pkg::*;

    logic [INSN_WIDTH-1:0]  data [QDEPTH];
    logic [INSN_WIDTH-1:0]  shift_src [QDEPTH];
    logic [QDEPTH:0]        is_head;        // one-hot, bit k set when k words are held.
    logic [QDEPTH-1:0]      take_new;
    logic                   do_push;
    logic                   do_pop;

    assign do_pop  = i_pop & !is_head[0];
    assign do_push = i_push & (!is_head[QDEPTH] | do_pop);

    genvar i;
    generate
        for (i = 0; i < QDEPTH; i++)
        begin : g_entry
            // the new word lands on the first free slot after any shift.
            assign take_new[i] = do_push & ((do_pop & is_head[i + 1]) | (!do_pop & is_head[i]));

            if (i == QDEPTH - 1)
            begin : g_last
                assign shift_src[i] = data[i];   // nothing behind the tail.
            end
            else
            begin : g_inner
                assign shift_src[i] = data[i + 1];
            end
        end
    endgenerate

    always_ff @(posedge i_clk)
    begin
        for (int k = 0; k < QDEPTH; k++)
        begin
            if (take_new[k])
            begin
                data[k] <= i_data;
            end
            else if (do_pop)
            begin
                data[k] <= shift_src[k];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            is_head <= (QDEPTH+1)'(1);
        end
        else if (i_flush)
        begin
            is_head <= (QDEPTH+1)'(1);
        end
        else if (do_push & !do_pop)
        begin
            is_head <= is_head << 1;
        end
        else if (do_pop & !do_push)
        begin
            is_head <= is_head >> 1;
        end
    end

    // occupancy from the head marker.
    always_comb
    begin
        o_count = '0;
        for (int k = 0; k <= QDEPTH; k++)
        begin
            if (is_head[k])
            begin
                o_count = QCOUNT_BITS'(k);
            end
        end
    end

    assign o_head      = data[0];
    assign o_not_empty = !is_head[0];

endmodule

// File: hdl/insn_align.sv
module insn_align
(
    input  wire                                     i_clk,
    input  wire                                     i_arst_n,
    input  wire                                     i_stall,
    input  wire                                     i_load,
    input  wire [rv_fetch_pkg::IADDR_BITS-1:1]      i_load_pc,
    input  wire                                     i_flush,
    input  wire [rv_fetch_pkg::INSN_WIDTH-1:0]      i_head,
    input  wire                                     i_not_empty,
    output logic                                    o_pop,
    output logic [rv_fetch_pkg::INSN_WIDTH-1:0]     o_insn,
    output logic [rv_fetch_pkg::IADDR_BITS-1:1]     o_insn_pc,
    output logic                                    o_insn_comp,
    output logic                                    o_insn_valid
);

    import rv_fetch_pkg::*;

    logic [IADDR_BITS-1:1]  pc;             // next instruction to extract.
    logic [IADDR_BITS-1:1]  pc_step;
    logic [15:0]            hi_latch;       // top half of the word popped last.
    logic                   hi_valid;
    logic [15:0]            half_lo;
    logic [15:0]            half_hi;
    logic                   is_comp;
    logic                   hold_off;
    logic                   advance;
    logic                   gather;
    logic                   ready;
    logic                   emit;
    logic                   word_done;

    assign hold_off = i_load | i_flush;

    // output register takes a new instruction unless decode holds the current one.
    assign advance = !o_insn_valid | !i_stall;

    // pc[1] clear: whole instruction starts at the head's low half.
    // pc[1] set:   it starts at the head's top half, or in the latch once gathered.
    assign half_lo = pc[1] ? (hi_valid ? hi_latch : i_head[31:16]) : i_head[15:0];
    assign half_hi = pc[1] ? i_head[15:0] : i_head[31:16];

    assign is_comp = half_lo[1:0] != 2'b11;

    // a 32-bit insn straddling words, park its low half first.
    assign gather = pc[1] & !hi_valid & !is_comp & i_not_empty & !hold_off;

    assign ready = i_not_empty & !(pc[1] & !hi_valid & !is_comp);
    assign emit  = ready & advance & !hold_off;

    // the head word is used up once its top halfword is consumed.
    assign word_done = pc[1] ? (!hi_valid & is_comp) : !is_comp;

    assign o_pop = gather | (emit & word_done);

    assign pc_step = is_comp ? (IADDR_BITS-1)'(1) : (IADDR_BITS-1)'(2);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc           <= RESET_PC;
            hi_valid     <= 1'b0;
            o_insn_valid <= 1'b0;
        end
        else
        begin
            if (i_load)
            begin
                pc <= i_load_pc;
            end
            else if (emit)
            begin
                pc <= pc + pc_step;
            end

            if (hold_off)
            begin
                hi_valid <= 1'b0;   // old path halfword is stale.
            end
            else if (gather)
            begin
                hi_valid <= 1'b1;
            end
            else if (emit & hi_valid)
            begin
                hi_valid <= 1'b0;
            end

            if (hold_off)
            begin
                o_insn_valid <= 1'b0;
            end
            else if (advance)
            begin
                o_insn_valid <= emit;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (gather)
        begin
            hi_latch <= i_head[31:16];
        end
        if (emit)
        begin
            o_insn      <= is_comp ? {16'h0000, half_lo} : {half_hi, half_lo};
            o_insn_pc   <= pc;
            o_insn_comp <= is_comp;
        end
    end

endmodule

// File: hdl/rv_fetch_top.sv
module rv_fetch_top
(
    input  wire                                     i_clk,
    input  wire                                     i_arst_n,
    output logic                                    o_imem_req,
    output logic [rv_fetch_pkg::WADDR_BITS-1:0]     o_imem_addr,
    input  wire                                     i_imem_valid,
    input  wire [rv_fetch_pkg::INSN_WIDTH-1:0]      i_imem_data,
    input  wire                                     i_stall,
    output logic [rv_fetch_pkg::INSN_WIDTH-1:0]     o_insn,
    output logic [rv_fetch_pkg::IADDR_BITS-1:1]     o_insn_pc,
    output logic                                    o_insn_comp,
    output logic                                    o_insn_valid,
    input  wire                                     i_redirect,
    input  wire [rv_fetch_pkg::IADDR_BITS-1:1]      i_redirect_pc
);

    import rv_fetch_pkg::*;

    logic                       q_push;
    logic                       flush;
    logic                       pop;
    logic [INSN_WIDTH-1:0]      head;
    logic [QCOUNT_BITS-1:0]     count;
    logic                       not_empty;
    logic                       align_load;
    logic [IADDR_BITS-1:1]      load_pc;

    fetch_ctrl u_ctrl
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_imem_valid   (i_imem_valid),
        .i_q_count      (count),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .o_q_push       (q_push),
        .o_flush        (flush),
        .o_align_load   (align_load),
        .o_load_pc      (load_pc)
    );

    // memory data goes straight into the queue.
    fetch_queue u_queue
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (flush),
        .i_push         (q_push),
        .i_data         (i_imem_data),
        .i_pop          (pop),
        .o_head         (head),
        .o_count        (count),
        .o_not_empty    (not_empty)
    );

    insn_align u_align
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_stall        (i_stall),
        .i_load         (align_load),
        .i_load_pc      (load_pc),
        .i_flush        (flush),
        .i_head         (head),
        .i_not_empty    (not_empty),
        .o_pop          (pop),
        .o_insn         (o_insn),
        .o_insn_pc      (o_insn_pc),
        .o_insn_comp    (o_insn_comp),
        .o_insn_valid   (o_insn_valid)
    );

endmodule

// File: bench/tb_imem.sv
module tb_imem
(
    input  wire                                     i_clk,
    input  wire                                     i_arst_n,
    input  wire                                     i_req,
    input  wire [rv_fetch_pkg::WADDR_BITS-1:0]      i_addr,
    output logic                                    o_valid,
    output logic [rv_fetch_pkg::INSN_WIDTH-1:0]     o_data
);

    import rv_fetch_pkg::*;

    // whole word address space, loaded by the testbench.
    logic [INSN_WIDTH-1:0]  mem [0:(2**WADDR_BITS)-1];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_req;   // fixed one-cycle latency.
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_data <= mem[i_addr];
    end

endmodule

// File: bench/tb_rv_fetch.sv
module tb_rv_fetch;

    import rv_fetch_pkg::*;

    logic                   clk;
    logic                   arst_n;
    logic                   stall;
    logic                   redirect;
    logic [IADDR_BITS-1:1]  redirect_pc;
    logic                   imem_req;
    logic [WADDR_BITS-1:0]  imem_addr;
    logic                   imem_valid;
    logic [INSN_WIDTH-1:0]  imem_data;
    logic [INSN_WIDTH-1:0]  insn;
    logic [IADDR_BITS-1:1]  insn_pc;
    logic                   insn_comp;
    logic                   insn_valid;

    logic [IADDR_BITS-1:1]  model_pc;   // next pc of the reference stream.
    logic [WADDR_BITS-1:0]  exp_waddr;  // next word the fetch must request.
    int                     errors;
    int                     tests_run;
    int                     tests_bad;
    bit                     timed_out;

    rv_fetch_top UUT
    (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .o_imem_req     (imem_req),
        .o_imem_addr    (imem_addr),
        .i_imem_valid   (imem_valid),
        .i_imem_data    (imem_data),
        .i_stall        (stall),
        .o_insn         (insn),
        .o_insn_pc      (insn_pc),
        .o_insn_comp    (insn_comp),
        .o_insn_valid   (insn_valid),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc)
    );

    tb_imem u_imem
    (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_req      (imem_req),
        .i_addr     (imem_addr),
        .o_valid    (imem_valid),
        .o_data     (imem_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] half_at(input logic [IADDR_BITS-1:1] hpc);
        logic [INSN_WIDTH-1:0] word;
        word = u_imem.mem[hpc[IADDR_BITS-1:2]];
        return hpc[1] ? word[31:16] : word[15:0];
    endfunction

    task automatic put_half(input logic [IADDR_BITS-1:1] hpc, input logic [15:0] value);
        logic [INSN_WIDTH-1:0] word;
        word = u_imem.mem[hpc[IADDR_BITS-1:2]];
        if (hpc[1])
            word[31:16] = value;
        else
            word[15:0] = value;
        u_imem.mem[hpc[IADDR_BITS-1:2]] = word;
    endtask

    // background words differ at every address.
    task automatic fill_memory();
        for (int a = 0; a < 2**WADDR_BITS; a++)
            u_imem.mem[WADDR_BITS'(a)] = {2'b10, WADDR_BITS'(a), 2'b01, ~WADDR_BITS'(a)};
    endtask

    // n random insns from start, full_pct of them 32-bit.
    task automatic write_program(input logic [IADDR_BITS-1:1] start, input int n,
                                 input int full_pct);
        logic [IADDR_BITS-1:1]  pc;
        logic [31:0]            r;
        pc = start;
        for (int i = 0; i < n; i++)
        begin
            r = $urandom;
            if ($urandom_range(0, 99) < full_pct)
            begin
                r[1:0] = 2'b11;
                put_half(pc, r[15:0]);
                put_half(pc + (IADDR_BITS-1)'(1), r[31:16]);
                pc = pc + (IADDR_BITS-1)'(2);
            end
            else
            begin
                r[1:0] = 2'($urandom_range(0, 2));
                put_half(pc, r[15:0]);
                pc = pc + (IADDR_BITS-1)'(1);
            end
        end
    endtask

    // requests walk the words in order from the one holding the start pc.
    task automatic check_request();
        if (imem_req === 1'b1)
        begin
            assert (imem_addr === exp_waddr)
            else
            begin
                $display("Error at %0t: request address %h, expected %h",
                         $time, imem_addr, exp_waddr);
                errors++;
            end
            exp_waddr = exp_waddr + WADDR_BITS'(1);
        end
    endtask

    // reference walk by halfwords, compared with what decode takes.
    task automatic check_next();
        logic [15:0]            lo;
        logic [INSN_WIDTH-1:0]  e_insn;
        logic                   e_comp;
        lo     = half_at(model_pc);
        e_comp = lo[1:0] != 2'b11;
        e_insn = e_comp ? {16'h0000, lo} : {half_at(model_pc + (IADDR_BITS-1)'(1)), lo};
        assert (insn === e_insn && insn_pc === model_pc && insn_comp === e_comp)
        else
        begin
            $display("Error at %0t: pc %h insn %h comp %b, expected pc %h insn %h comp %b",
                     $time, insn_pc, insn, insn_comp, model_pc, e_insn, e_comp);
            errors++;
        end
        model_pc = model_pc + (e_comp ? (IADDR_BITS-1)'(1) : (IADDR_BITS-1)'(2));
    endtask

    task automatic collect(input int n, input bit stall_on);
        int                     got;
        int                     idle;       // cycles since the last insn taken.
        bit                     held;
        logic [INSN_WIDTH-1:0]  h_insn;
        logic [IADDR_BITS-1:1]  h_pc;
        got  = 0;
        idle = 0;
        held = 1'b0;
        while (got < n && !timed_out)
        begin
            @(posedge clk);
            #2 stall = stall_on && ($urandom % 2 == 0);
            @(negedge clk);
            check_request();
            if (held)
            begin
                assert (insn_valid === 1'b1 && insn === h_insn && insn_pc === h_pc)
                else
                begin
                    $display("Error at %0t: output changed under stall, pc %h insn %h",
                             $time, insn_pc, insn);
                    errors++;
                end
            end
            held   = insn_valid && stall;
            h_insn = insn;
            h_pc   = insn_pc;
            if (insn_valid && !stall)
            begin
                check_next();
                got++;
                idle = 0;
            end
            else
            begin
                idle++;
                if (idle == 50)
                begin
                    $display("timeout waiting for instruction, %0d of %0d received at %0t",
                             got, n, $time);
                    errors++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    // with take_old low decode stalls through the pulse.
    task automatic redirect_to(input logic [IADDR_BITS-1:1] pc, input bit take_old);
        @(posedge clk);
        #2;
        redirect    = 1'b1;
        redirect_pc = pc;
        stall       = !take_old;
        @(negedge clk);
        check_request();
        if (take_old && insn_valid)
            check_next();   // taken in the redirect cycle, still old path.
        @(posedge clk);
        #2;
        redirect  = 1'b0;
        stall     = 1'b0;
        model_pc  = pc;
        exp_waddr = pc[IADDR_BITS-1:2];
        @(negedge clk);
        check_request();
        assert (insn_valid === 1'b0)
        else
        begin
            $display("Error at %0t: old path insn pc %h still valid after redirect",
                     $time, insn_pc);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("[%0t] %s: ok", $time, name);
        end
        else
        begin
            tests_bad++;
            $display("[%0t] %s: %0d errors", $time, name, errors - errors_before);
        end
    endtask

    task automatic run_reset();
        int e0;
        e0 = errors;
        fill_memory();
        write_program(RESET_PC, 16, 50);
        for (int c = 0; c < 5; c++)
        begin
            @(negedge clk);
            assert (imem_req === 1'b0 && insn_valid === 1'b0)
            else
            begin
                $display("Error at %0t: request or insn valid active in reset", $time);
                errors++;
            end
        end
        @(posedge clk);
        #2 arst_n = 1'b1;
        model_pc  = RESET_PC;
        exp_waddr = RESET_PC[IADDR_BITS-1:2];
        collect(10, 1'b0);
        end_test("reset", e0);
    endtask

    task automatic run_aligned();
        int e0;
        e0 = errors;
        fill_memory();
        write_program(15'h080, 24, 100);
        redirect_to(15'h080, 1'b0);
        collect(20, 1'b0);
        end_test("aligned 32-bit stream", e0);
    endtask

    task automatic run_mixed();
        int e0;
        e0 = errors;
        fill_memory();
        write_program(15'h101, 1, 100);     // unaligned 32-bit start.
        write_program(15'h103, 60, 50);
        redirect_to(15'h101, 1'b0);
        collect(50, 1'b0);
        end_test("mixed stream", e0);
    endtask

    task automatic run_backpressure();
        int e0;
        e0 = errors;
        fill_memory();
        write_program(15'h300, 80, 50);
        redirect_to(15'h300, 1'b0);
        collect(60, 1'b1);
        end_test("back-pressure", e0);
    endtask

    task automatic run_redirect();
        int e0;
        e0 = errors;
        fill_memory();
        write_program(15'h200, 40, 50);
        write_program(15'h401, 1, 0);       // compressed on an odd halfword.
        write_program(15'h402, 20, 50);
        write_program(15'h601, 1, 100);     // 32-bit straddling two words.
        write_program(15'h603, 20, 50);
        redirect_to(15'h200, 1'b0);
        collect(6, 1'b0);
        redirect_to(15'h401, 1'b1);
        collect(10, 1'b0);
        redirect_to(15'h601, 1'b1);
        collect(10, 1'b1);
        end_test("redirect", e0);
    endtask

    initial
    begin
        arst_n      = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        model_pc    = RESET_PC;
        exp_waddr   = '0;
        errors      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        timed_out   = 1'b0;
        void'($urandom(52219));
        run_reset();
        if (!timed_out)
            run_aligned();
        if (!timed_out)
            run_mixed();
        if (!timed_out)
            run_backpressure();
        if (!timed_out)
            run_redirect();
        $display("tests run %0d, ok %0d, failing %0d, errors %0d",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: rv_fetch.f
hdl/rv_fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/fetch_queue.sv
hdl/insn_align.sv
hdl/rv_fetch_top.sv
bench/tb_imem.sv
bench/tb_rv_fetch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rv_fetch
FILELIST  := rv_fetch.f
SIMFLAGS  := --binary --timing --assert
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
